//--- rtl/core_video_pkg.sv
// shared types and constants for the video output path
// bridge words are 32 bits wide and big endian, as the host sends them
// reset-hold default assumes the 74.25 MHz bridge clock

package core_video_pkg;

  ////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////

  // bridge address or data word
  typedef logic [31:0] bridge_word_t;

  // one pixel, red in [23:16], green in [15:8], blue in [7:0]
  typedef logic [23:0] rgb_t;

  // adapter settings word as stored by the core
  typedef logic [16:0] analog_settings_t;

  ////////////////////////////////////////////////////////////
  // bridge address map
  ////////////////////////////////////////////////////////////

  // write here to hold the core in reset for a while
  localparam bridge_word_t BRIDGE_ADDR_RESET = 32'h0000_0050;

  // adapter settings, written and read back at the same address
  localparam bridge_word_t BRIDGE_ADDR_ANALOG_SETTINGS = 32'hF700_0000;

  // settings word fields
  // bit 16 turns the handheld screen black
  localparam int SETTINGS_BLANK_BIT = 16;

  ////////////////////////////////////////////////////////////
  // video constants
  ////////////////////////////////////////////////////////////

  // marker colour the scaler reads as the slot end of a line
  // only bits 14 and 13 set
  localparam rgb_t VIDEO_SLOT_RGB = 24'h00_6000;

  // hsync delay, keeps the hsync pulse clear of vsync
  localparam int HS_DELAY_DEFAULT = 7;

  // reset hold after a write to the reset address, in clk_74a cycles
  localparam int RESET_HOLD_DEFAULT = 32'h0010_0000;

endpackage

//--- rtl/bridge_settings_regs.sv
// host bridge settings block, single clock domain on clk_74a
// bridge_rd_data is combinational from bridge_addr, no read strobe
// RESET_HOLD_CYCLES must be 1 or more
// addresses other than the reset and settings ones are ignored

`timescale 1ns/1ps

module bridge_settings_regs #(
  parameter int RESET_HOLD_CYCLES = core_video_pkg::RESET_HOLD_DEFAULT
) (
  input  logic                        clk_74a,
  input  logic                        pll_core_locked,
  // host bridge
  input  core_video_pkg::bridge_word_t bridge_addr,
  input  logic                        bridge_wr,
  input  core_video_pkg::bridge_word_t bridge_wr_data,
  output core_video_pkg::bridge_word_t bridge_rd_data,
  // settings out
  output logic                        blank_screen,
  output logic                        core_reset
);

  import core_video_pkg::*;

  // counter wide enough to hold the full hold length
  localparam int HOLD_W = $clog2(RESET_HOLD_CYCLES + 1);
  localparam logic [HOLD_W-1:0] HOLD_LOAD = HOLD_W'(RESET_HOLD_CYCLES);

  ////////////////////////////////////////////////////////////
  // write decode
  ////////////////////////////////////////////////////////////

  logic             wr_settings;
  logic             wr_reset;
  analog_settings_t settings_word;
  logic [HOLD_W-1:0] hold_cnt;

  // one-cycle strobes, address qualified
  assign wr_settings = bridge_wr && (bridge_addr == BRIDGE_ADDR_ANALOG_SETTINGS);
  assign wr_reset    = bridge_wr && (bridge_addr == BRIDGE_ADDR_RESET);

  ////////////////////////////////////////////////////////////
  // settings word
  ////////////////////////////////////////////////////////////

  // low 17 data bits kept, the rest dropped
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings_word <= '0;
    end else if (wr_settings) begin
      settings_word <= bridge_wr_data[$bits(analog_settings_t)-1:0];
    end
  end

  // screen blank is a plain level
  assign blank_screen = settings_word[SETTINGS_BLANK_BIT];

  ////////////////////////////////////////////////////////////
  // readback mux
  ////////////////////////////////////////////////////////////

  // zero-extended settings at its address
  // everything else reads as zero
  always_comb begin
    bridge_rd_data = '0;
    if (bridge_addr == BRIDGE_ADDR_ANALOG_SETTINGS) begin
      bridge_rd_data = bridge_word_t'(settings_word);
    end
  end

  ////////////////////////////////////////////////////////////
  // reset hold
  ////////////////////////////////////////////////////////////

  // loaded by a reset write, then counts down to zero
  // a write during the hold restarts the full length
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_cnt <= '0;
    end else if (wr_reset) begin
      hold_cnt <= HOLD_LOAD;
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  // high for exactly RESET_HOLD_CYCLES cycles after the write edge
  assign core_reset = (hold_cnt != '0);

endmodule

//--- rtl/video_sync_capture.sv
// registers the emulator's raw video outputs on clk_74a
// every cycle is a pixel cycle, there is no pixel enable
// edge strobes are combinational and line up with cap_rgb

`timescale 1ns/1ps

module video_sync_capture (
  input  logic                clk_74a,
  input  logic                pll_core_locked,
  // raw emulator video
  input  core_video_pkg::rgb_t pixel_rgb,
  input  logic                h_blank,
  input  logic                v_blank,
  input  logic                hsync,
  input  logic                vsync,
  // captured video and events
  output core_video_pkg::rgb_t cap_rgb,
  output logic                cap_de,
  output logic                de_fall,
  output logic                hs_rise,
  output logic                vs_rise
);

  logic hs_q;
  logic vs_q;
  logic de_prev;
  logic hs_prev;
  logic vs_prev;

  ////////////////////////////////////////////////////////////
  // input stage and previous copies
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      cap_rgb <= '0;
      cap_de  <= 1'b0;
      hs_q    <= 1'b0;
      vs_q    <= 1'b0;
      de_prev <= 1'b0;
      hs_prev <= 1'b0;
      vs_prev <= 1'b0;
    end else begin
      cap_rgb <= pixel_rgb;
      // active picture only when neither blank is up
      cap_de  <= ~(h_blank | v_blank);
      hs_q    <= hsync;
      vs_q    <= vsync;
      // one cycle behind the captured values
      de_prev <= cap_de;
      hs_prev <= hs_q;
      vs_prev <= vs_q;
    end
  end

  // single-cycle events
  assign de_fall = de_prev & ~cap_de;
  assign hs_rise = hs_q & ~hs_prev;
  assign vs_rise = vs_q & ~vs_prev;

endmodule

//--- rtl/video_out_formatter.sv
// scaler-facing video outputs, all registered on clk_74a
// hsync comes out HS_DELAY cycles after the hs_rise strobe
// HS_DELAY must be 2 or more
// a new hs_rise during the countdown restarts it

`timescale 1ns/1ps

module video_out_formatter #(
  parameter int HS_DELAY = core_video_pkg::HS_DELAY_DEFAULT
) (
  input  logic                clk_74a,
  input  logic                pll_core_locked,
  // from the capture stage
  input  core_video_pkg::rgb_t cap_rgb,
  input  logic                cap_de,
  input  logic                de_fall,
  input  logic                hs_rise,
  input  logic                vs_rise,
  // from the settings block
  input  logic                blank_screen,
  // to the scaler
  output core_video_pkg::rgb_t video_rgb,
  output logic                video_de,
  output logic                video_hs,
  output logic                video_vs
);

  import core_video_pkg::*;

  localparam int HS_W = $clog2(HS_DELAY + 1);
  localparam logic [HS_W-1:0] HS_LOAD = HS_W'(HS_DELAY);

  logic [HS_W-1:0] hs_cnt;
  rgb_t            next_rgb;

  ////////////////////////////////////////////////////////////
  // colour select
  ////////////////////////////////////////////////////////////

  // pixel during active video, black when the screen is blanked
  // marker colour on the first cycle after active video
  always_comb begin
    next_rgb = '0;
    if (cap_de) begin
      if (!blank_screen) begin
        next_rgb = cap_rgb;
      end
    end else if (de_fall) begin
      next_rgb = VIDEO_SLOT_RGB;
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_rgb <= '0;
      video_de  <= 1'b0;
      video_vs  <= 1'b0;
    end else begin
      video_rgb <= next_rgb;
      video_de  <= cap_de;
      // vsync out as a single pulse on the rising edge
      video_vs  <= vs_rise;
    end
  end

  ////////////////////////////////////////////////////////////
  // hsync delay
  ////////////////////////////////////////////////////////////

  // countdown loaded on hs_rise, pulse as it reaches one
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_cnt   <= '0;
      video_hs <= 1'b0;
    end else begin
      // reload drops the pending pulse, only the later one appears
      video_hs <= (hs_cnt == HS_W'(2)) && !hs_rise;
      if (hs_rise) begin
        hs_cnt <= HS_LOAD;
      end else if (hs_cnt != '0) begin
        hs_cnt <= hs_cnt - 1'b1;
      end
    end
  end

endmodule

//--- rtl/core_video_out.sv
// video output and bridge settings path of the core top level
// single clock clk_74a, pll_core_locked is the async active-low reset
// video latency is 2 cycles, hsync latency is HS_DELAY + 1 cycles

`timescale 1ns/1ps

module core_video_out #(
  parameter int RESET_HOLD_CYCLES = core_video_pkg::RESET_HOLD_DEFAULT,
  parameter int HS_DELAY          = core_video_pkg::HS_DELAY_DEFAULT
) (
  input  logic                        clk_74a,
  input  logic                        pll_core_locked,
  // host bridge
  input  core_video_pkg::bridge_word_t bridge_addr,
  input  logic                        bridge_wr,
  input  core_video_pkg::bridge_word_t bridge_wr_data,
  output core_video_pkg::bridge_word_t bridge_rd_data,
  output logic                        core_reset,
  // emulator video
  input  core_video_pkg::rgb_t         pixel_rgb,
  input  logic                        h_blank,
  input  logic                        v_blank,
  input  logic                        hsync,
  input  logic                        vsync,
  // scaler video
  output core_video_pkg::rgb_t         video_rgb,
  output logic                        video_de,
  output logic                        video_hs,
  output logic                        video_vs
);

  import core_video_pkg::*;

  // settings to formatter
  logic blank_screen;

  // capture to formatter
  rgb_t cap_rgb;
  logic cap_de;
  logic de_fall;
  logic hs_rise;
  logic vs_rise;

  ////////////////////////////////////////////////////////////
  // bridge settings
  ////////////////////////////////////////////////////////////

  bridge_settings_regs #(
    .RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)
  ) bridge_settings_regs_inst (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd_data (bridge_rd_data),
    .blank_screen   (blank_screen),
    .core_reset     (core_reset)
  );

  ////////////////////////////////////////////////////////////
  // video path
  ////////////////////////////////////////////////////////////

  video_sync_capture video_sync_capture_inst (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .pixel_rgb      (pixel_rgb),
    .h_blank        (h_blank),
    .v_blank        (v_blank),
    .hsync          (hsync),
    .vsync          (vsync),
    .cap_rgb        (cap_rgb),
    .cap_de         (cap_de),
    .de_fall        (de_fall),
    .hs_rise        (hs_rise),
    .vs_rise        (vs_rise)
  );

  video_out_formatter #(
    .HS_DELAY(HS_DELAY)
  ) video_out_formatter_inst (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .cap_rgb        (cap_rgb),
    .cap_de         (cap_de),
    .de_fall        (de_fall),
    .hs_rise        (hs_rise),
    .vs_rise        (vs_rise),
    .blank_screen   (blank_screen),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs)
  );

endmodule

//--- testbench/tb_clock_gen.sv
// clock and reset source for the testbench
// 4 ns clk_74a, pll_core_locked low for the first 3 rising edges

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD_NS = 2,
  parameter int RESET_CYCLES   = 3
) (
  output logic clk_74a,
  output logic pll_core_locked
);

  initial begin
    clk_74a = 1'b0;
    forever #(HALF_PERIOD_NS) clk_74a = ~clk_74a;
  end

  // released on a rising edge, first live edge is the one after
  initial begin
    pll_core_locked = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_74a);
    pll_core_locked <= 1'b1;
  end

endmodule

//--- testbench/tb_video_checker.sv
// watches the DUT ports and compares every cycle on the falling edge
// inputs are recorded on the falling edge before the rising edge that samples them
// expects the inputs to change only on rising edges

`timescale 1ns/1ps

module tb_video_checker #(
  parameter int HOLD_CYCLES = 20,
  parameter int HS_DELAY    = core_video_pkg::HS_DELAY_DEFAULT
) (
  input  logic                         clk_74a,
  input  logic                         pll_core_locked,
  input  core_video_pkg::bridge_word_t bridge_addr,
  input  logic                         bridge_wr,
  input  core_video_pkg::bridge_word_t bridge_wr_data,
  input  core_video_pkg::bridge_word_t bridge_rd_data,
  input  logic                         core_reset,
  input  core_video_pkg::rgb_t         pixel_rgb,
  input  logic                         h_blank,
  input  logic                         v_blank,
  input  logic                         hsync,
  input  logic                         vsync,
  input  core_video_pkg::rgb_t         video_rgb,
  input  logic                         video_de,
  input  logic                         video_hs,
  input  logic                         video_vs,
  output int                           mismatch_count,
  output int                           failed_tests
);

  import core_video_pkg::*;

  // hsync history, enough to see a rise HS_DELAY edges back
  localparam int HW = HS_DELAY + 2;

  // inputs as the next rising edge will sample them
  logic             pend_live;
  logic             pend_de;
  logic             pend_hs;
  logic             pend_vs;
  rgb_t             pend_rgb;
  logic             pend_wr;
  bridge_word_t     pend_addr;
  bridge_word_t     pend_data;

  // sampled history, index 0 is the latest edge
  logic [2:0]       de_hist;
  logic [HW-1:0]    hs_hist;
  logic [2:0]       vs_hist;
  rgb_t             rgb_m0;
  rgb_t             rgb_m1;
  analog_settings_t settings_model;
  int               rst_age;
  logic             blank_used;
  logic [26:0]      exp_video;
  logic [32:0]      exp_bridge;

  int               test_errors;
  int               tests_run;

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // outputs after edge m, packed as {rgb, de, hs, vs}
  function automatic logic [26:0] predict_video(
    input logic [2:0]    de_h,
    input logic [HW-1:0] hs_h,
    input logic [2:0]    vs_h,
    input rgb_t          rgb_prev,
    input logic          blank
  );
    rgb_t rgb;
    logic rise_due;
    logic later_rise;
    int   k;
    // two-stage path, enable from the edge before
    if (de_h[1]) begin
      rgb = blank ? 24'h0 : rgb_prev;
    end else if (de_h[2]) begin
      rgb = VIDEO_SLOT_RGB;
    end else begin
      rgb = 24'h0;
    end
    // hsync rise HS_DELAY edges ago, no newer rise since
    rise_due   = hs_h[HS_DELAY] & ~hs_h[HS_DELAY+1];
    later_rise = 1'b0;
    for (k = 1; k < HS_DELAY; k++) begin
      if (hs_h[k] && !hs_h[k+1]) begin
        later_rise = 1'b1;
      end
    end
    return {rgb, de_h[1], rise_due & ~later_rise, vs_h[1] & ~vs_h[2]};
  endfunction

  // readback and hold status, packed as {rd_data, core_reset}
  function automatic logic [32:0] predict_bridge(
    input bridge_word_t     addr,
    input analog_settings_t word,
    input int               age
  );
    bridge_word_t rd;
    logic         busy;
    rd   = (addr == BRIDGE_ADDR_ANALOG_SETTINGS) ? {15'd0, word} : 32'd0;
    // high from the write edge for HOLD_CYCLES edges
    busy = (age >= 0) && (age < HOLD_CYCLES);
    return {rd, busy};
  endfunction

  ////////////////////////////////////////////////////////////
  // comparison
  ////////////////////////////////////////////////////////////

  task automatic check_value(
    input string       name,
    input logic [31:0] expected,
    input logic [31:0] actual
  );
    if (actual !== expected) begin
      $display("FAILED t=%0t %s expected %h got %h", $time, name, expected, actual);
      test_errors++;
      mismatch_count++;
    end
  endtask

  initial begin
    pend_live      = 1'b0;
    pend_de        = 1'b0;
    pend_hs        = 1'b0;
    pend_vs        = 1'b0;
    pend_rgb       = '0;
    pend_wr        = 1'b0;
    pend_addr      = '0;
    pend_data      = '0;
    de_hist        = '0;
    hs_hist        = '0;
    vs_hist        = '0;
    rgb_m0         = '0;
    rgb_m1         = '0;
    settings_model = '0;
    rst_age        = -1;
    test_errors    = 0;
    tests_run      = 0;
    mismatch_count = 0;
    failed_tests   = 0;
  end

  always @(negedge clk_74a) begin
    // blank level the formatter saw at the edge just passed
    blank_used = settings_model[SETTINGS_BLANK_BIT];
    if (pend_live) begin
      de_hist = {de_hist[1:0], pend_de};
      hs_hist = {hs_hist[HW-2:0], pend_hs};
      vs_hist = {vs_hist[1:0], pend_vs};
      rgb_m1  = rgb_m0;
      rgb_m0  = pend_rgb;
      if (pend_wr && pend_addr == BRIDGE_ADDR_ANALOG_SETTINGS) begin
        settings_model = pend_data[16:0];
      end
      if (pend_wr && pend_addr == BRIDGE_ADDR_RESET) begin
        rst_age = 0;
      end else if (rst_age >= 0 && rst_age < HOLD_CYCLES) begin
        rst_age++;
      end
    end else begin
      // reset edge, everything back to idle
      de_hist        = '0;
      hs_hist        = '0;
      vs_hist        = '0;
      rgb_m0         = '0;
      rgb_m1         = '0;
      settings_model = '0;
      rst_age        = -1;
    end

    exp_video  = predict_video(de_hist, hs_hist, vs_hist, rgb_m1, blank_used);
    exp_bridge = predict_bridge(bridge_addr, settings_model, rst_age);

    check_value("video_rgb", {8'h0, exp_video[26:3]}, {8'h0, video_rgb});
    check_value("video_de", {31'd0, exp_video[2]}, {31'd0, video_de});
    check_value("video_hs", {31'd0, exp_video[1]}, {31'd0, video_hs});
    check_value("video_vs", {31'd0, exp_video[0]}, {31'd0, video_vs});
    check_value("bridge_rd_data", exp_bridge[32:1], bridge_rd_data);
    check_value("core_reset", {31'd0, exp_bridge[0]}, {31'd0, core_reset});

    // record what the next rising edge will sample
    pend_live = pll_core_locked;
    pend_de   = ~(h_blank | v_blank);
    pend_hs   = hsync;
    pend_vs   = vsync;
    pend_rgb  = pixel_rgb;
    pend_wr   = bridge_wr;
    pend_addr = bridge_addr;
    pend_data = bridge_wr_data;
  end

  ////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////

  task automatic close_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: %0d mismatches", tests_run, name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic report_counts();
    $display("tests run %0d, with mismatches %0d, total mismatches %0d",
             tests_run, failed_tests, mismatch_count);
  endtask

endmodule

//--- testbench/tb_core_video_out.sv
// testbench top for core_video_out, drives the bridge and the raw video inputs
// RESET_HOLD_CYCLES is shortened to 20, HS_DELAY stays at its default
// stimulus is driven on rising edges only

`timescale 1ns/1ps

module tb_core_video_out;

  import core_video_pkg::*;

  localparam int HOLD_CYCLES  = 20;
  localparam int VIDEO_CYCLES = 200;
  // two video runs plus the shorter tests, timeout at about three times that
  localparam int RUN_CYCLES     = 2 * VIDEO_CYCLES + 250;
  localparam int TIMEOUT_CYCLES = 3 * RUN_CYCLES + 50;

  logic         clk_74a;
  logic         pll_core_locked;
  bridge_word_t bridge_addr;
  logic         bridge_wr;
  bridge_word_t bridge_wr_data;
  bridge_word_t bridge_rd_data;
  logic         core_reset;
  rgb_t         pixel_rgb;
  logic         h_blank;
  logic         v_blank;
  logic         hsync;
  logic         vsync;
  rgb_t         video_rgb;
  logic         video_de;
  logic         video_hs;
  logic         video_vs;

  int           mismatch_count;
  int           failed_tests;
  int           cycle_count;
  logic [31:0]  rng;
  int           i;

  tb_clock_gen tb_clock_gen_inst (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked)
  );

  core_video_out #(
    .RESET_HOLD_CYCLES(HOLD_CYCLES)
  ) core_video_out_inst (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd_data (bridge_rd_data),
    .core_reset     (core_reset),
    .pixel_rgb      (pixel_rgb),
    .h_blank        (h_blank),
    .v_blank        (v_blank),
    .hsync          (hsync),
    .vsync          (vsync),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs)
  );

  tb_video_checker #(
    .HOLD_CYCLES(HOLD_CYCLES),
    .HS_DELAY   (HS_DELAY_DEFAULT)
  ) tb_video_checker_inst (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd_data (bridge_rd_data),
    .core_reset     (core_reset),
    .pixel_rgb      (pixel_rgb),
    .h_blank        (h_blank),
    .v_blank        (v_blank),
    .hsync          (hsync),
    .vsync          (vsync),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs),
    .mismatch_count (mismatch_count),
    .failed_tests   (failed_tests)
  );

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // any address except the two decoded ones
  function automatic bridge_word_t unrelated_address(input logic [31:0] r);
    if (r == BRIDGE_ADDR_ANALOG_SETTINGS || r == BRIDGE_ADDR_RESET) begin
      return r ^ 32'h1;
    end
    return r;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_74a);
  endtask

  // one-cycle write strobe, address left in place afterwards
  task automatic bridge_write(input bridge_word_t addr, input bridge_word_t data);
    @(posedge clk_74a);
    bridge_addr    <= addr;
    bridge_wr      <= 1'b1;
    bridge_wr_data <= data;
    @(posedge clk_74a);
    bridge_wr      <= 1'b0;
  endtask

  task automatic bridge_read(input bridge_word_t addr);
    @(posedge clk_74a);
    bridge_addr <= addr;
    @(posedge clk_74a);
  endtask

  // random pixel and blanking every cycle, then blank and flush
  task automatic run_video(input int cycles);
    int n;
    for (n = 0; n < cycles; n++) begin
      rng = xorshift32(rng);
      @(posedge clk_74a);
      pixel_rgb <= rng[23:0];
      h_blank   <= (rng[26:25] == 2'b00);
      v_blank   <= (rng[31:28] == 4'h0);
    end
    @(posedge clk_74a);
    pixel_rgb <= '0;
    h_blank   <= 1'b1;
    v_blank   <= 1'b1;
    idle_cycles(4);
  endtask

  task automatic wait_reset_release();
    do @(negedge clk_74a); while (core_reset);
  endtask

  task automatic wait_hs_pulse();
    do @(negedge clk_74a); while (!video_hs);
  endtask

  task automatic wait_vs_pulse();
    do @(negedge clk_74a); while (!video_vs);
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rng            = 32'h43f4;
    bridge_addr    = BRIDGE_ADDR_ANALOG_SETTINGS;
    bridge_wr      = 1'b0;
    bridge_wr_data = '0;
    pixel_rgb      = '0;
    h_blank        = 1'b1;
    v_blank        = 1'b1;
    hsync          = 1'b0;
    vsync          = 1'b0;

    wait (pll_core_locked == 1'b1);
    idle_cycles(6);
    tb_video_checker_inst.close_test("after reset");

    // settings word, other reads, unrelated write
    rng = xorshift32(rng);
    bridge_write(BRIDGE_ADDR_ANALOG_SETTINGS, rng);
    idle_cycles(2);
    for (i = 0; i < 8; i++) begin
      rng = xorshift32(rng);
      bridge_read(unrelated_address(rng));
    end
    rng = xorshift32(rng);
    bridge_write(unrelated_address(rng), xorshift32(rng));
    bridge_read(BRIDGE_ADDR_ANALOG_SETTINGS);
    idle_cycles(2);
    tb_video_checker_inst.close_test("settings register");

    // second write lands in the middle of the hold
    bridge_write(BRIDGE_ADDR_RESET, 32'h0);
    idle_cycles(8);
    bridge_write(BRIDGE_ADDR_RESET, 32'h0);
    wait_reset_release();
    idle_cycles(3);
    tb_video_checker_inst.close_test("reset hold");

    rng = xorshift32(rng);
    bridge_write(BRIDGE_ADDR_ANALOG_SETTINGS, rng & ~32'h0001_0000);
    run_video(VIDEO_CYCLES);
    tb_video_checker_inst.close_test("video path");

    rng = xorshift32(rng);
    bridge_write(BRIDGE_ADDR_ANALOG_SETTINGS, rng | 32'h0001_0000);
    run_video(VIDEO_CYCLES);
    bridge_write(BRIDGE_ADDR_ANALOG_SETTINGS, 32'h0);
    idle_cycles(2);
    tb_video_checker_inst.close_test("screen blank");

    // vsync rises
    repeat (2) begin
      @(posedge clk_74a);
      vsync <= 1'b1;
      wait_vs_pulse();
      @(posedge clk_74a);
      vsync <= 1'b0;
      idle_cycles(4);
    end
    // isolated hsync rises
    repeat (2) begin
      @(posedge clk_74a);
      hsync <= 1'b1;
      idle_cycles(2);
      hsync <= 1'b0;
      wait_hs_pulse();
      idle_cycles(4);
    end
    // two rises 3 cycles apart, only the later pulse
    @(posedge clk_74a);
    hsync <= 1'b1;
    @(posedge clk_74a);
    hsync <= 1'b0;
    idle_cycles(2);
    hsync <= 1'b1;
    @(posedge clk_74a);
    hsync <= 1'b0;
    wait_hs_pulse();
    idle_cycles(HS_DELAY_DEFAULT + 4);
    tb_video_checker_inst.close_test("sync pulses");

    tb_video_checker_inst.report_counts();
    if (failed_tests == 0 && mismatch_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_74a);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("tests failed");
    $finish;
  end

endmodule

//--- core_video_out.f
rtl/core_video_pkg.sv
rtl/bridge_settings_regs.sv
rtl/video_sync_capture.sv
rtl/video_out_formatter.sv
rtl/core_video_out.sv
testbench/tb_clock_gen.sv
testbench/tb_video_checker.sv
testbench/tb_core_video_out.sv
